/* hdl/core_pkg.sv */
package core_pkg;

  // Datapath widths
  localparam int XLEN      = 64;                 // Integer register width
  localparam int ILEN      = 32;                 // Instruction word width
  localparam int NUM_REGS  = 32;                 // Architectural registers
  localparam int REG_IDX_W = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]      xlen_t;          // Register value
  typedef logic [XLEN-1:0]      addr_t;          // Instruction address
  typedef logic [ILEN-1:0]      inst_t;          // Raw instruction
  typedef logic [REG_IDX_W-1:0] reg_idx_t;       // Register number
  typedef logic [6:0]           opcode_t;        // Major opcode field

  localparam addr_t    INST_BYTES = addr_t'(4);  // PC step
  localparam reg_idx_t SP_REG     = reg_idx_t'(2);

  // Major opcodes handled by the core
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 codes for OP
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;   // Selects SUB at funct3 000

  typedef enum logic [3:0] {
    ADD,                                         // a + b
    SUB,                                         // a - b
    AND,
    OR,
    XOR,
    SLT,                                         // Signed less-than, 1 or 0
    SLTU,                                        // Unsigned less-than
    PASS_B,                                      // LUI takes b as is
    LINK                                         // JAL return address
  } alu_op_e;

  // Fetch port FSM
  typedef enum logic [1:0] {
    IDLE,                                        // Nothing outstanding
    WAIT,                                        // Request out, answer wanted
    WAIT_STALE                                   // Request out, answer to be dropped
  } fetch_state_e;

endpackage

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::xlen_t    stackptr,   // x2 value after reset
  input  core_pkg::reg_idx_t rs1_idx,
  input  core_pkg::reg_idx_t rs2_idx,
  output core_pkg::xlen_t    rs1_data,
  output core_pkg::xlen_t    rs2_data,
  input  logic               wb_valid,   // Retiring write this cycle
  input  core_pkg::reg_idx_t wb_reg,
  input  core_pkg::xlen_t    wb_data
);

  core_pkg::xlen_t regs [core_pkg::NUM_REGS];

  // Write port leaves x0 at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= (i == int'(core_pkg::SP_REG)) ? stackptr : '0;
      end
    end else if (wb_valid && wb_reg != '0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // Read ports see the value being written in the same cycle
  assign rs1_data = (wb_valid && wb_reg == rs1_idx && rs1_idx != '0) ? wb_data
                                                                      : regs[rs1_idx];
  assign rs2_data = (wb_valid && wb_reg == rs2_idx && rs2_idx != '0) ? wb_data
                                                                      : regs[rs2_idx];

  // Execute strobes only writes to real registers
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_reg != '0));

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic            clk,
  input  logic            reset,
  input  core_pkg::addr_t entry,         // Start address, sampled in reset
  output logic            fetch_req,     // One-cycle request strobe
  output core_pkg::addr_t fetch_addr,
  input  logic            fetch_valid,   // One-cycle answer strobe
  input  core_pkg::inst_t fetch_data,
  input  logic            stall_decode,
  input  logic            flush,
  input  logic            redirect,
  input  core_pkg::addr_t redirect_pc,
  output logic            if_valid,      // IF/ID holds an instruction
  output core_pkg::inst_t if_inst,
  output core_pkg::addr_t if_pc
);

  core_pkg::fetch_state_e state;
  core_pkg::addr_t        pc;          // Next address to fetch
  core_pkg::addr_t        next_pc;     // pc with any redirect applied
  logic                   slot_free;   // IF/ID empty after this edge
  logic                   issue;       // Raise fetch_req next cycle
  logic                   accept;      // Answer goes into IF/ID

  assign next_pc   = redirect ? redirect_pc : pc;
  assign slot_free = !if_valid || !stall_decode || flush;
  assign accept    = (state == core_pkg::WAIT) && fetch_valid && !redirect;

  // Wrong-path answers free the port for the jump target at once
  assign issue = ((state == core_pkg::IDLE) && slot_free) ||
                 ((state == core_pkg::WAIT) && fetch_valid && redirect) ||
                 ((state == core_pkg::WAIT_STALE) && fetch_valid);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= core_pkg::IDLE;
      pc        <= entry;
      fetch_req <= 1'b0;
      if_valid  <= 1'b0;
    end else begin
      fetch_req <= issue;
      pc        <= accept ? pc + core_pkg::INST_BYTES : next_pc;
      if (issue)
        state <= core_pkg::WAIT;
      else if (accept)
        state <= core_pkg::IDLE;
      else if (state == core_pkg::WAIT && redirect)
        state <= core_pkg::WAIT_STALE;          // Answer still on its way
      if (flush)
        if_valid <= 1'b0;
      else if (accept)
        if_valid <= 1'b1;
      else if (!stall_decode)
        if_valid <= 1'b0;                       // Taken by decode
    end
  end

  always_ff @(posedge clk) begin
    if (issue) fetch_addr <= next_pc;
    if (accept) begin
      if_inst <= fetch_data;
      if_pc   <= pc;
    end
  end

  a_no_resp_idle: assert property (@(posedge clk) disable iff (reset)
    fetch_valid |-> (state != core_pkg::IDLE));
  // Single request in flight
  a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    fetch_req |=> (!fetch_req until_with fetch_valid));

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 if_valid,
  input  core_pkg::inst_t      if_inst,
  input  core_pkg::addr_t      if_pc,
  input  logic                 stall_decode,
  input  logic                 flush,
  output core_pkg::reg_idx_t   rs1_idx,
  output core_pkg::reg_idx_t   rs2_idx,
  output logic                 uses_rs1,   // rs1 is a real operand
  output logic                 uses_rs2,
  input  core_pkg::xlen_t      rs1_data,
  input  core_pkg::xlen_t      rs2_data,
  output logic                 ex_valid,   // ID/EX occupied
  output core_pkg::alu_op_e    ex_op,
  output core_pkg::xlen_t      ex_a,
  output core_pkg::xlen_t      ex_b,
  output core_pkg::reg_idx_t   ex_rd,
  output logic                 ex_jump,
  output core_pkg::addr_t      ex_pc,
  output core_pkg::xlen_t      ex_imm
);

  core_pkg::opcode_t  opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  core_pkg::xlen_t    imm_i;
  core_pkg::xlen_t    imm_u;
  core_pkg::xlen_t    imm_j;
  core_pkg::xlen_t    imm_sel;     // Immediate sent on to execute
  core_pkg::alu_op_e  op;
  logic               legal;       // In the supported subset
  logic               use_imm;     // Operand b is the immediate
  logic               jump;
  logic               load;        // Real instruction enters ID/EX

  assign opcode  = if_inst[6:0];
  assign funct3  = if_inst[14:12];
  assign funct7  = if_inst[31:25];
  assign rs1_idx = if_inst[19:15];
  assign rs2_idx = if_inst[24:20];

  // Sign-extended immediates
  assign imm_i = core_pkg::xlen_t'($signed(if_inst[31:20]));
  assign imm_u = core_pkg::xlen_t'($signed({if_inst[31:12], 12'b0}));
  assign imm_j = core_pkg::xlen_t'($signed({if_inst[31], if_inst[19:12], if_inst[20],
                                            if_inst[30:21], 1'b0}));

  always_comb begin
    legal    = 1'b1;
    op       = core_pkg::ADD;
    use_imm  = 1'b1;
    imm_sel  = imm_i;
    jump     = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      core_pkg::OPC_OP_IMM, core_pkg::OPC_OP: begin
        uses_rs1 = 1'b1;
        case (funct3)
          core_pkg::F3_ADD_SUB: op = core_pkg::ADD;
          core_pkg::F3_SLT:     op = core_pkg::SLT;
          core_pkg::F3_SLTU:    op = core_pkg::SLTU;
          core_pkg::F3_XOR:     op = core_pkg::XOR;
          core_pkg::F3_OR:      op = core_pkg::OR;
          core_pkg::F3_AND:     op = core_pkg::AND;
          default:              legal = 1'b0;   // Shifts fall here
        endcase
        if (opcode == core_pkg::OPC_OP) begin
          uses_rs2 = 1'b1;
          use_imm  = 1'b0;
          if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_SUB)
            op = core_pkg::SUB;
          else if (funct7 != core_pkg::F7_BASE)
            legal = 1'b0;                       // Other funct7 encodings
        end
      end
      core_pkg::OPC_LUI: begin
        op      = core_pkg::PASS_B;
        imm_sel = imm_u;
      end
      core_pkg::OPC_JAL: begin
        op      = core_pkg::LINK;
        imm_sel = imm_j;
        jump    = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin         // Retires as a silent no-op
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
      jump     = 1'b0;
    end
  end

  assign load = if_valid && !stall_decode && !flush;

  // ID/EX register, a bubble when nothing moves in
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_jump  <= 1'b0;
    end else begin
      ex_valid <= load;
      ex_jump  <= load && jump;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ex_op  <= op;
      ex_a   <= rs1_data;
      ex_b   <= use_imm ? imm_sel : rs2_data;
      ex_rd  <= legal ? if_inst[11:7] : '0;
      ex_pc  <= if_pc;
      ex_imm <= imm_sel;
    end
  end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               ex_valid,
  input  core_pkg::alu_op_e  ex_op,
  input  core_pkg::xlen_t    ex_a,
  input  core_pkg::xlen_t    ex_b,
  input  core_pkg::reg_idx_t ex_rd,
  input  logic               ex_jump,
  input  core_pkg::addr_t    ex_pc,
  input  core_pkg::xlen_t    ex_imm,
  output logic               jump_taken,    // JAL in ID/EX this cycle
  output core_pkg::addr_t    jump_target,
  output logic               wb_valid,      // EX/WB write strobe
  output core_pkg::reg_idx_t wb_reg,
  output core_pkg::xlen_t    wb_data
);

  core_pkg::xlen_t alu_out;

  // 64-bit ALU, sums wrap around
  always_comb begin
    case (ex_op)
      core_pkg::ADD:    alu_out = ex_a + ex_b;
      core_pkg::SUB:    alu_out = ex_a - ex_b;
      core_pkg::AND:    alu_out = ex_a & ex_b;
      core_pkg::OR:     alu_out = ex_a | ex_b;
      core_pkg::XOR:    alu_out = ex_a ^ ex_b;
      core_pkg::SLT:    alu_out = core_pkg::xlen_t'($signed(ex_a) < $signed(ex_b));
      core_pkg::SLTU:   alu_out = core_pkg::xlen_t'(ex_a < ex_b);
      core_pkg::PASS_B: alu_out = ex_b;                             // LUI
      core_pkg::LINK:   alu_out = ex_pc + core_pkg::INST_BYTES;     // Return address
      default:          alu_out = '0;
    endcase
  end

  // PC-relative target of a JAL
  assign jump_target = ex_pc + ex_imm;
  assign jump_taken  = ex_valid && ex_jump;

  // EX/WB control, x0 destinations never strobe
  always_ff @(posedge clk) begin
    if (reset)
      wb_valid <= 1'b0;
    else
      wb_valid <= ex_valid && (ex_rd != '0);
  end

  always_ff @(posedge clk) begin
    wb_reg  <= ex_rd;
    wb_data <= alu_out;
  end

  // The flush behind a jump leaves a bubble in ID/EX
  a_jump_single: assert property (@(posedge clk) disable iff (reset)
    jump_taken |=> !jump_taken);

endmodule

/* hdl/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
  input  logic               if_valid,
  input  core_pkg::reg_idx_t rs1_idx,
  input  core_pkg::reg_idx_t rs2_idx,
  input  logic               uses_rs1,
  input  logic               uses_rs2,
  input  logic               ex_valid,     // ID/EX entry
  input  core_pkg::reg_idx_t ex_rd,
  input  logic               wb_valid,     // EX/WB entry
  input  core_pkg::reg_idx_t wb_reg,
  input  logic               jump_taken,
  input  core_pkg::addr_t    jump_target,
  output logic               stall_decode, // Holds IF/ID and bubbles ID/EX
  output logic               flush,        // Empty IF/ID and ID/EX
  output logic               redirect,
  output core_pkg::addr_t    redirect_pc
);

  logic rs1_hazard;
  logic rs2_hazard;

  // Source register still waiting on an older result
  function automatic logic pending_write(
    input core_pkg::reg_idx_t src,
    input logic               ex_v,
    input core_pkg::reg_idx_t ex_r,
    input logic               wb_v,
    input core_pkg::reg_idx_t wb_r
  );
    return (src != '0) && ((ex_v && ex_r == src) || (wb_v && wb_r == src));
  endfunction

  assign rs1_hazard = uses_rs1 && pending_write(rs1_idx, ex_valid, ex_rd, wb_valid, wb_reg);
  assign rs2_hazard = uses_rs2 && pending_write(rs2_idx, ex_valid, ex_rd, wb_valid, wb_reg);

  // Jump resolved in execute
  assign flush       = jump_taken;
  assign redirect    = jump_taken;      // One cycle since ID/EX is bubbled behind it
  assign redirect_pc = jump_target;

  // Wrong-path instruction in IF/ID is dropped rather than held
  assign stall_decode = if_valid && (rs1_hazard || rs2_hazard) && !flush;

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::addr_t    entry,        // First PC
  input  core_pkg::xlen_t    stackptr,     // Initial x2
  output logic               fetch_req,
  output core_pkg::addr_t    fetch_addr,
  input  logic               fetch_valid,
  input  core_pkg::inst_t    fetch_data,
  output logic               wb_valid,     // Retired write, same cycle as the RF update
  output core_pkg::reg_idx_t wb_reg,
  output core_pkg::xlen_t    wb_data
);

  // IF/ID
  logic               if_valid;
  core_pkg::inst_t    if_inst;
  core_pkg::addr_t    if_pc;
  // Register reads
  core_pkg::reg_idx_t rs1_idx;
  core_pkg::reg_idx_t rs2_idx;
  core_pkg::xlen_t    rs1_data;
  core_pkg::xlen_t    rs2_data;
  logic               uses_rs1;
  logic               uses_rs2;
  // ID/EX
  logic               ex_valid;
  core_pkg::alu_op_e  ex_op;
  core_pkg::xlen_t    ex_a;
  core_pkg::xlen_t    ex_b;
  core_pkg::reg_idx_t ex_rd;
  logic               ex_jump;
  core_pkg::addr_t    ex_pc;
  core_pkg::xlen_t    ex_imm;
  // Control
  logic               jump_taken;
  core_pkg::addr_t    jump_target;
  logic               stall_decode;
  logic               flush;
  logic               redirect;
  core_pkg::addr_t    redirect_pc;

  register_file u_regs (
    .clk(clk), .reset(reset), .stackptr(stackptr),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  fetch_unit u_fetch (
    .clk(clk), .reset(reset), .entry(entry),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch_data(fetch_data),
    .stall_decode(stall_decode), .flush(flush),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc)
  );

  inst_decoder u_decode (
    .clk(clk), .reset(reset),
    .if_valid(if_valid), .if_inst(if_inst), .if_pc(if_pc),
    .stall_decode(stall_decode), .flush(flush),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_rd(ex_rd),
    .ex_jump(ex_jump), .ex_pc(ex_pc), .ex_imm(ex_imm)
  );

  execute_unit u_exec (
    .clk(clk), .reset(reset),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_rd(ex_rd),
    .ex_jump(ex_jump), .ex_pc(ex_pc), .ex_imm(ex_imm),
    .jump_taken(jump_taken), .jump_target(jump_target),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  pipe_control u_ctrl (
    .if_valid(if_valid), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
    .ex_valid(ex_valid), .ex_rd(ex_rd), .wb_valid(wb_valid), .wb_reg(wb_reg),
    .jump_taken(jump_taken), .jump_target(jump_target),
    .stall_decode(stall_decode), .flush(flush),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

endmodule

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  logic               clk;
  logic               reset;
  core_pkg::addr_t    entry;
  core_pkg::xlen_t    stackptr;
  logic               fetch_req;
  core_pkg::addr_t    fetch_addr;
  logic               fetch_valid;
  core_pkg::inst_t    fetch_data;
  logic               wb_valid;
  core_pkg::reg_idx_t wb_reg;
  core_pkg::xlen_t    wb_data;

  core_pkg::inst_t    prog [64];          // Program with word 0 at entry
  int                 prog_len;
  core_pkg::addr_t    cur_entry;
  core_pkg::xlen_t    cur_sp;
  core_pkg::reg_idx_t exp_reg [$];        // Expected write-backs in retire order
  core_pkg::xlen_t    exp_data [$];
  core_pkg::addr_t    jump_targets [$];   // Taken-path jump targets from the model
  core_pkg::addr_t    fetch_log [$];      // Every request since reset
  logic [31:0]        lfsr;
  int                 err_count;
  int                 test_start;
  int                 tests_run;
  int                 tests_failed;

  rv_core DUT (
    .clk(clk), .reset(reset), .entry(entry), .stackptr(stackptr),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch_data(fetch_data),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic take_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // Custom-0 words keyed on the whole address fill the space outside the program
  function automatic core_pkg::inst_t fetch_word(input core_pkg::addr_t a);
    if (a >= cur_entry && a < cur_entry + 4 * prog_len && a[1:0] == 2'b00)
      return prog[(a - cur_entry) >> 2];
    return {a[24:0] ^ a[49:25] ^ {11'b0, a[63:50]}, 7'b0001011};
  endfunction

  // Fetch memory answering 1 to 4 cycles after the request
  always begin : fetch_memory
    core_pkg::addr_t req_addr;
    int              delay;
    @(negedge clk);
    fetch_valid <= 1'b0;
    if (!reset && fetch_req) begin
      req_addr = fetch_addr;
      delay    = 1 + (take_bit() ? 2 : 0);
      delay    = delay + (take_bit() ? 1 : 0);
      repeat (delay) @(negedge clk);
      fetch_valid <= !reset;                // Answer dropped if reset came in between
      fetch_data  <= fetch_word(req_addr);
    end
  end

  task automatic check_reg_idx(input string name, input core_pkg::reg_idx_t got,
                               input core_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_xlen(input string name, input core_pkg::xlen_t got,
                            input core_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input core_pkg::addr_t got,
                            input core_pkg::addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // Sampled mid-cycle away from the DUT's clock edge
  always @(negedge clk) begin : port_monitor
    if (!reset && fetch_req)
      fetch_log.push_back(fetch_addr);
    if (!reset && wb_valid) begin
      if (exp_reg.size() == 0) begin
        $display("Unexpected write-back to x%0d with data %h", wb_reg, wb_data);
        err_count++;
      end else begin
        check_reg_idx("wb_reg", wb_reg, exp_reg.pop_front());
        check_xlen("wb_data", wb_data, exp_data.pop_front());
      end
    end
  end

  // Assemblers for the kept formats
  function automatic core_pkg::inst_t imm_inst(input logic [2:0] f3, input int rd,
                                               input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], core_pkg::OPC_OP_IMM};
  endfunction

  function automatic core_pkg::inst_t reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                               input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], core_pkg::OPC_OP};
  endfunction

  function automatic core_pkg::inst_t lui_inst(input int rd, input logic [19:0] imm20);
    return {imm20, rd[4:0], core_pkg::OPC_LUI};
  endfunction

  function automatic core_pkg::inst_t jal_inst(input int rd, input int offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], core_pkg::OPC_JAL};
  endfunction

  task automatic append_inst(input core_pkg::inst_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // OP and OP-IMM arithmetic by funct3 with ok low for shifts
  function automatic core_pkg::xlen_t alu_result(input logic [2:0] f3, input logic sub,
      input core_pkg::xlen_t a, input core_pkg::xlen_t b, output logic ok);
    ok = 1'b1;
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b011:  return (a < b) ? 64'd1 : 64'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: ok = 1'b0;
    endcase
    return '0;
  endfunction

  // In-order model filling the expected write-back list
  task automatic run_model();
    core_pkg::xlen_t regs [32];
    core_pkg::addr_t pc;
    core_pkg::addr_t next_pc;
    core_pkg::inst_t w;
    core_pkg::xlen_t b;
    core_pkg::xlen_t val;
    logic            writes;
    exp_reg.delete();
    exp_data.delete();
    jump_targets.delete();
    foreach (regs[i]) regs[i] = '0;
    regs[2] = cur_sp;
    pc = cur_entry;
    for (int step = 0; step < 200; step++) begin
      if (pc < cur_entry || pc >= cur_entry + 4 * prog_len)
        break;                              // Left the program
      w       = prog[(pc - cur_entry) >> 2];
      b       = (w[6:0] == core_pkg::OPC_OP) ? regs[w[24:20]] : {{52{w[31]}}, w[31:20]};
      next_pc = pc + 4;
      writes  = 1'b1;
      case (w[6:0])
        core_pkg::OPC_OP_IMM: val = alu_result(w[14:12], 1'b0, regs[w[19:15]], b, writes);
        core_pkg::OPC_OP: begin
          val = alu_result(w[14:12], w[30], regs[w[19:15]], b, writes);
          if (w[31:25] != 7'h00 && !(w[31:25] == 7'h20 && w[14:12] == 3'b000))
            writes = 1'b0;
        end
        core_pkg::OPC_LUI: val = {{32{w[31]}}, w[31:12], 12'h000};
        core_pkg::OPC_JAL: begin
          val     = pc + 4;                 // Link
          next_pc = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
          jump_targets.push_back(next_pc);
        end
        default: writes = 1'b0;
      endcase
      if (writes && w[11:7] != 5'd0) begin
        regs[w[11:7]] = val;
        exp_reg.push_back(w[11:7]);
        exp_data.push_back(val);
      end
      pc = next_pc;
    end
  endtask

  task automatic apply_reset(input core_pkg::addr_t ent, input core_pkg::xlen_t sp);
    @(negedge clk);
    reset    <= 1'b1;
    entry    <= ent;
    stackptr <= sp;
    repeat (4) @(negedge clk);
    reset <= 1'b0;
    fetch_log.delete();
  endtask

  // Reset, model, then wait until every expected write has retired
  task automatic run_program(input core_pkg::addr_t ent, input core_pkg::xlen_t sp);
    int cycles;
    test_start = err_count;
    cur_entry  = ent;
    cur_sp     = sp;
    apply_reset(ent, sp);
    run_model();
    cycles = 0;
    while (exp_reg.size() != 0 && cycles < 600) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_reg.size() != 0) begin
      $display("Timeout, %0d write-backs never arrived", exp_reg.size());
      err_count++;
    end
    repeat (16) @(negedge clk);             // Stray writes show up here
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count == test_start) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed, %0d errors", name, err_count - test_start);
    end
  endtask

  task automatic test_entry_and_sp();
    prog_len = 0;
    append_inst(imm_inst(3'b000, 5, 2, 0));   // addi x5, x2, 0
    append_inst(imm_inst(3'b000, 6, 5, 8));
    run_program(64'h0000_0000_0000_1000, 64'h0000_003f_ffff_fff0);
    if (fetch_log.size() == 0) begin
      $display("No fetch request was seen after reset");
      err_count++;
    end else begin
      check_addr("fetch_addr", fetch_log[0], 64'h0000_0000_0000_1000);
    end
    finish_test("entry_and_sp");
  endtask

  task automatic test_reg_imm();
    prog_len = 0;
    append_inst(imm_inst(3'b000, 5, 2, -16));
    append_inst(imm_inst(3'b111, 6, 5, -256));
    append_inst(imm_inst(3'b110, 7, 0, -2048));
    append_inst(imm_inst(3'b100, 8, 5, -1));
    append_inst(imm_inst(3'b010, 9, 8, -5));
    append_inst(imm_inst(3'b010, 10, 7, -2047));
    append_inst(imm_inst(3'b011, 11, 5, -1));   // Unsigned against all ones
    append_inst(imm_inst(3'b011, 12, 0, -3));
    append_inst(imm_inst(3'b000, 13, 7, -1));
    run_program(64'h0000_0000_8000_0000, 64'h0000_0000_8000_0000);
    finish_test("reg_imm");
  endtask

  task automatic test_reg_reg();
    prog_len = 0;
    append_inst(imm_inst(3'b000, 5, 0, -7));
    append_inst(imm_inst(3'b000, 6, 0, 100));
    append_inst(reg_inst(7'h00, 3'b000, 7, 5, 6));    // Each reads the one before
    append_inst(reg_inst(7'h20, 3'b000, 8, 7, 5));
    append_inst(reg_inst(7'h00, 3'b111, 9, 8, 7));
    append_inst(reg_inst(7'h00, 3'b110, 10, 9, 5));
    append_inst(reg_inst(7'h00, 3'b100, 11, 10, 8));
    append_inst(reg_inst(7'h00, 3'b010, 12, 11, 5));
    append_inst(reg_inst(7'h00, 3'b011, 13, 5, 11));
    append_inst(reg_inst(7'h20, 3'b000, 14, 13, 12));
    run_program(64'h0000_0000_0000_2000, 64'h0000_0000_8000_1000);
    finish_test("reg_reg");
  endtask

  task automatic test_lui_and_x0();
    prog_len = 0;
    append_inst(lui_inst(13, 20'h80000));          // Negative upper immediate
    append_inst(lui_inst(14, 20'h12345));
    append_inst(imm_inst(3'b000, 0, 14, 5));       // Write to x0
    append_inst(32'h0050_038b);                    // Custom-0 with rd x7
    append_inst(imm_inst(3'b001, 12, 13, 3));      // slli is outside the kept set
    append_inst(reg_inst(7'h00, 3'b000, 15, 0, 14));
    append_inst(reg_inst(7'h00, 3'b110, 16, 0, 0));
    run_program(64'h0000_0000_0000_3000, 64'h0000_0000_0001_0000);
    finish_test("lui_and_x0");
  endtask

  task automatic test_jal();
    logic redirect_seen;
    prog_len = 0;
    append_inst(imm_inst(3'b000, 5, 0, 7));
    append_inst(jal_inst(1, 12));                  // Over the next two
    append_inst(imm_inst(3'b000, 6, 0, 1));
    append_inst(imm_inst(3'b000, 7, 0, 2));
    append_inst(imm_inst(3'b000, 8, 1, 1));
    append_inst(reg_inst(7'h00, 3'b000, 9, 8, 5));
    run_program(64'h0000_0000_0004_0000, 64'h0);
    redirect_seen = 1'b0;
    for (int i = 1; i < fetch_log.size(); i++) begin
      if (!redirect_seen && fetch_log[i] != fetch_log[i-1] + 4) begin
        check_addr("fetch_addr", fetch_log[i], jump_targets[0]);
        redirect_seen = 1'b1;
      end
    end
    if (!redirect_seen) begin
      $display("The core never fetched from the jump target");
      err_count++;
    end
    finish_test("jal");
  endtask

  task automatic test_mixed();
    prog_len = 0;
    append_inst(lui_inst(5, 20'hfffff));
    append_inst(imm_inst(3'b000, 6, 5, -1));
    append_inst(reg_inst(7'h20, 3'b000, 7, 6, 2));
    append_inst(reg_inst(7'h00, 3'b011, 8, 2, 7));
    append_inst(reg_inst(7'h00, 3'b010, 9, 7, 2));
    append_inst(jal_inst(0, 8));                   // Plain jump without a link
    append_inst(imm_inst(3'b000, 10, 0, 99));
    append_inst(reg_inst(7'h00, 3'b100, 10, 6, 2));
    append_inst(jal_inst(11, 8));
    append_inst(reg_inst(7'h00, 3'b110, 12, 0, 0));
    append_inst(reg_inst(7'h00, 3'b111, 12, 10, 11));
    append_inst(imm_inst(3'b110, 13, 12, -1366));
    append_inst(32'h0000_070b);
    append_inst(imm_inst(3'b000, 14, 13, 1));
    run_program(64'h0000_0000_0010_0000, 64'h0000_0000_0020_0000);
    finish_test("mixed");
  endtask

  initial begin
    reset        = 1'b1;
    entry        = '0;
    stackptr     = '0;
    fetch_valid  = 1'b0;
    fetch_data   = '0;
    lfsr         = 32'hfb051409;
    prog_len     = 0;
    cur_entry    = '0;
    cur_sp       = '0;
    err_count    = 0;
    test_start   = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_entry_and_sp();
    test_reg_imm();
    test_reg_reg();
    test_lui_and_x0();
    test_jal();
    test_mixed();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* rv_core.f */
hdl/core_pkg.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/execute_unit.sv
hdl/pipe_control.sv
hdl/rv_core.sv
tb/tb_rv_core.sv
